/* files.f */
+incdir+tb
common/riscv_pkg.sv
core/register_file.sv
core/singlecycle_datapath.sv
core/singlecycle_ctlpath.sv
core/data_memory_interface.sv
core/riscv_core.sv
tb/riscv_core_tb.sv

/* Bender.yml */
package:
  name: riscv_core

sources:
  - common/riscv_pkg.sv
  - core/register_file.sv
  - core/singlecycle_datapath.sv
  - core/singlecycle_ctlpath.sv
  - core/data_memory_interface.sv
  - core/riscv_core.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/riscv_core_tb.sv

/* tb/tb_program.svh */
// Instruction encoders, the test program and its table of expected stores.
// Included inside the testbench module; build_program fills imem, exp_next and the table.

`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// ======================================================================
// RV32I encoders
// ======================================================================
function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                       input logic [4:0] rd, rs1, rs2);
  return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic logic [31:0] i_word(input logic [6:0] opc, input logic [2:0] f3,
                                       input logic [4:0] rd, rs1, input logic [11:0] imm);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] s_word(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                       input logic [11:0] imm);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
endfunction

function automatic logic [31:0] b_word(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                       input logic [12:0] imm);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
endfunction

function automatic logic [31:0] u_word(input logic [6:0] opc, input logic [4:0] rd,
                                       input logic [19:0] imm);
  return {imm, rd, opc};
endfunction

function automatic logic [31:0] j_word(input logic [4:0] rd, input logic [20:0] imm);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
endfunction

// ======================================================================
// Program builders
// ======================================================================
task automatic control_flow(input logic [31:0] word, input logic [31:0] target);
  imem[prog_len]     = word;
  exp_next[prog_len] = target;
  prog_len++;
endtask

task automatic add_inst(input logic [31:0] word);
  control_flow(word, 4 * prog_len + 4);
endtask

task automatic expect_store(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] be);
  exp_addr[n_exp] = addr;
  exp_data[n_exp] = data;
  exp_be[n_exp]   = be;
  n_exp++;
endtask

// Stores a register to the next word of the result area at 0x300
task automatic store_reg(input logic [4:0] rd, input logic [31:0] value);
  add_inst(s_word(3'b010, 5'd1, rd, store_off));
  expect_store({20'h0, store_off} + 32'h300, value, 4'b1111);
  store_off += 12'd4;
endtask

task automatic checked_op(input logic [31:0] word, input logic [4:0] rd,
                          input logic [31:0] value);
  add_inst(word);
  store_reg(rd, value);
endtask

// Not-taken branch, taken branch, then a slot the taken branch skips
task automatic branch_pair(input logic [2:0] f3, input logic [4:0] na, nb, ta, tb);
  control_flow(b_word(f3, na, nb, 13'd8), 4 * prog_len + 4);
  control_flow(b_word(f3, ta, tb, 13'd8), 4 * prog_len + 8);
  add_inst(i_word(OPC_OP_IMM, 3'b000, 5'd9, 5'd9, 12'd1));
endtask

task automatic build_program();
  int          k;
  logic [31:0] link;
  prog_len  = 0;
  n_exp     = 0;
  store_off = 12'd0;

  // x1 = result base, x2 = 0x123, x3 = -6, x4 = 0x87654000
  add_inst(i_word(OPC_OP_IMM, 3'b000, 5'd1, 5'd0, 12'h300));
  checked_op(i_word(OPC_OP_IMM, 3'b000, 5'd2, 5'd0, 12'h123), 5'd2, 32'h0000_0123);
  checked_op(i_word(OPC_OP_IMM, 3'b000, 5'd3, 5'd0, 12'hFFA), 5'd3, 32'hFFFF_FFFA);
  checked_op(u_word(OPC_LUI, 5'd4, 20'h87654), 5'd4, 32'h8765_4000);
  checked_op(u_word(OPC_AUIPC, 5'd5, 20'h00012), 5'd5, 32'h0001_2000 + 4 * prog_len);

  checked_op(r_word(7'h00, 3'b000, 5'd6, 5'd2, 5'd3), 5'd6, 32'h0000_011D);  // add
  checked_op(r_word(7'h20, 3'b000, 5'd6, 5'd2, 5'd3), 5'd6, 32'h0000_0129);  // sub
  checked_op(r_word(7'h00, 3'b001, 5'd6, 5'd2, 5'd3), 5'd6, 32'h8C00_0000);  // sll by 26
  checked_op(r_word(7'h00, 3'b010, 5'd6, 5'd3, 5'd2), 5'd6, 32'h0000_0001);  // slt
  checked_op(r_word(7'h00, 3'b011, 5'd6, 5'd3, 5'd2), 5'd6, 32'h0000_0000);  // sltu
  checked_op(r_word(7'h00, 3'b100, 5'd6, 5'd2, 5'd3), 5'd6, 32'hFFFF_FED9);  // xor
  checked_op(r_word(7'h00, 3'b101, 5'd6, 5'd4, 5'd2), 5'd6, 32'h10EC_A800);  // srl by 3
  checked_op(r_word(7'h20, 3'b101, 5'd6, 5'd4, 5'd2), 5'd6, 32'hF0EC_A800);  // sra by 3
  checked_op(r_word(7'h00, 3'b110, 5'd6, 5'd2, 5'd4), 5'd6, 32'h8765_4123);  // or
  checked_op(r_word(7'h00, 3'b111, 5'd6, 5'd2, 5'd3), 5'd6, 32'h0000_0122);  // and

  checked_op(i_word(OPC_OP_IMM, 3'b010, 5'd6, 5'd2, 12'hFFF), 5'd6, 32'h0000_0000);
  checked_op(i_word(OPC_OP_IMM, 3'b011, 5'd6, 5'd2, 12'hFFF), 5'd6, 32'h0000_0001);
  checked_op(i_word(OPC_OP_IMM, 3'b100, 5'd6, 5'd2, 12'hFFF), 5'd6, 32'hFFFF_FEDC);
  checked_op(i_word(OPC_OP_IMM, 3'b110, 5'd6, 5'd4, 12'h0F0), 5'd6, 32'h8765_40F0);
  checked_op(i_word(OPC_OP_IMM, 3'b111, 5'd6, 5'd3, 12'h07F), 5'd6, 32'h0000_007A);
  checked_op(i_word(OPC_OP_IMM, 3'b001, 5'd6, 5'd2, 12'h008), 5'd6, 32'h0001_2300);
  checked_op(i_word(OPC_OP_IMM, 3'b101, 5'd6, 5'd4, 12'h004), 5'd6, 32'h0876_5400);
  checked_op(i_word(OPC_OP_IMM, 3'b101, 5'd6, 5'd4, 12'h404), 5'd6, 32'hF876_5400);
  checked_op(i_word(OPC_OP_IMM, 3'b000, 5'd0, 5'd2, 12'h001), 5'd0, 32'h0000_0000);

  // Byte and halfword stores of x2 at every offset
  for (k = 0; k < 4; k++) begin
    add_inst(s_word(3'b000, 5'd1, 5'd2, 12'h0C0 + 12'(k)));
    expect_store(32'h3C0, 32'h23 << (8 * k), 4'b0001 << k);
  end
  for (k = 0; k < 2; k++) begin
    add_inst(s_word(3'b001, 5'd1, 5'd2, 12'h0C4 + 12'(2 * k)));
    expect_store(32'h3C4, 32'h0123 << (16 * k), 4'b0011 << (2 * k));
  end

  // Word 0 of the preload has its top byte and top halfword negative
  checked_op(i_word(OPC_LOAD, 3'b010, 5'd6, 5'd0, 12'h010), 5'd6, load_value(32'h10, 3'b010));
  checked_op(i_word(OPC_LOAD, 3'b000, 5'd6, 5'd0, 12'h003), 5'd6, load_value(32'h03, 3'b000));
  checked_op(i_word(OPC_LOAD, 3'b100, 5'd6, 5'd0, 12'h003), 5'd6, load_value(32'h03, 3'b100));
  checked_op(i_word(OPC_LOAD, 3'b001, 5'd6, 5'd0, 12'h002), 5'd6, load_value(32'h02, 3'b001));
  checked_op(i_word(OPC_LOAD, 3'b101, 5'd6, 5'd0, 12'h002), 5'd6, load_value(32'h02, 3'b101));

  branch_pair(3'b000, 5'd2, 5'd3, 5'd2, 5'd2);  // beq
  branch_pair(3'b001, 5'd2, 5'd2, 5'd2, 5'd3);  // bne
  branch_pair(3'b100, 5'd2, 5'd3, 5'd3, 5'd2);  // blt
  branch_pair(3'b101, 5'd3, 5'd2, 5'd2, 5'd3);  // bge
  branch_pair(3'b110, 5'd3, 5'd2, 5'd2, 5'd3);  // bltu
  branch_pair(3'b111, 5'd2, 5'd3, 5'd3, 5'd2);  // bgeu

  // Jumps skip two slots; the JALR target has bit 0 set on purpose
  link = 4 * prog_len + 4;
  control_flow(j_word(5'd7, 21'd12), 4 * prog_len + 12);
  add_inst(i_word(OPC_OP_IMM, 3'b000, 5'd9, 5'd9, 12'd1));
  add_inst(i_word(OPC_OP_IMM, 3'b000, 5'd9, 5'd9, 12'd1));
  store_reg(5'd7, link);
  link = 4 * prog_len + 4;
  control_flow(i_word(OPC_JALR, 3'b000, 5'd8, 5'd0, 12'(4 * prog_len + 13)),
               4 * prog_len + 12);
  add_inst(i_word(OPC_OP_IMM, 3'b000, 5'd9, 5'd9, 12'd1));
  add_inst(i_word(OPC_OP_IMM, 3'b000, 5'd9, 5'd9, 12'd1));
  store_reg(5'd8, link);

  store_reg(5'd9, 32'h0000_0000);  // No skipped slot ran
  control_flow(j_word(5'd0, 21'd0), 4 * prog_len);
endtask

`endif

/* tb/riscv_core_tb.sv */
// Testbench for the single-cycle RV32I core.
// Models instruction and data memory, runs the program from tb_program.svh and
// checks the pc trace, the read enable and every bus store with concurrent assertions.

`timescale 1ns/1ps

module riscv_core_tb
  import riscv_pkg::*;
();

  logic        clock;
  logic        rst_n;
  logic [31:0] inst;
  logic [31:0] pc;
  logic [31:0] bus_address;
  logic [31:0] bus_read_data;
  logic [31:0] bus_write_data;
  logic [3:0]  bus_byte_enable;
  logic        bus_read_enable;
  logic        bus_write_enable;

  logic [31:0] imem     [0:127];
  logic [31:0] exp_next [0:127];  // Expected pc after each instruction
  logic [31:0] dmem     [0:255];
  logic [31:0] ref_mem  [0:255];  // Untouched copy of the preload
  logic [31:0] exp_addr [0:63];
  logic [31:0] exp_data [0:63];
  logic [3:0]  exp_be   [0:63];

  int          prog_len;
  int          n_exp;
  logic [11:0] store_off;
  int          store_idx = 0;
  int          mismatches = 0;
  int          failures;
  int          cycles;
  int          cycle_limit;
  logic [31:0] seed;
  logic [31:0] expected_pc;
  logic [31:0] last_pc;
  logic        tracking = 1'b0;
  logic        done;

  riscv_core dut (
    .clock            (clock),
    .rst_n            (rst_n),
    .inst             (inst),
    .pc               (pc),
    .bus_address      (bus_address),
    .bus_read_data    (bus_read_data),
    .bus_write_data   (bus_write_data),
    .bus_byte_enable  (bus_byte_enable),
    .bus_read_enable  (bus_read_enable),
    .bus_write_enable (bus_write_enable)
  );

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [31:0] lane_mask(input logic [3:0] be);
    return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
  endfunction

  // Sign or zero extended lane of the preloaded memory, per RV32I load rules
  function automatic logic [31:0] load_value(input logic [31:0] addr, input logic [2:0] f3);
    logic [31:0] word;
    logic [7:0]  byte_lane;
    logic [15:0] half_lane;
    word      = ref_mem[addr[9:2]];
    byte_lane = word[8*addr[1:0] +: 8];
    half_lane = word[16*addr[1] +: 16];
    case (f3)
      3'b000:  return {{24{byte_lane[7]}}, byte_lane};
      3'b100:  return {24'b0, byte_lane};
      3'b001:  return {{16{half_lane[15]}}, half_lane};
      3'b101:  return {16'b0, half_lane};
      default: return word;
    endcase
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    mismatches++;
    $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
  endtask

  `include "tb_program.svh"

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // ======================================================================
  // Memory models
  // ======================================================================
  always @(posedge clock) begin
    #1;
    inst = imem[pc[8:2]];  // Fetch follows the new pc
  end

  assign bus_read_data = dmem[bus_address[9:2]];

  always @(posedge clock) begin
    if (bus_write_enable) begin
      dmem[bus_address[9:2]] <= (dmem[bus_address[9:2]] & ~lane_mask(bus_byte_enable)) |
                                (bus_write_data & lane_mask(bus_byte_enable));
    end
    if (rst_n && bus_write_enable) begin
      store_idx <= store_idx + 1;
    end
  end

  // ======================================================================
  // Checks
  // ======================================================================
  always @(posedge clock) begin
    expected_pc <= rst_n ? exp_next[pc[8:2]] : RESET_PC;  // pc after this edge
    tracking    <= 1'b1;
  end

  assert property (@(posedge clock) $rose(rst_n) |-> pc == RESET_PC)
    else report_mismatch("reset_pc", RESET_PC, $sampled(pc));

  assert property (@(posedge clock) tracking |-> pc == expected_pc)
    else report_mismatch("pc_sequence", $sampled(expected_pc), $sampled(pc));

  assert property (@(posedge clock) disable iff (!rst_n)
      bus_write_enable |-> bus_address == exp_addr[store_idx])
    else report_mismatch("store_address", exp_addr[$sampled(store_idx)],
                         $sampled(bus_address));

  assert property (@(posedge clock) disable iff (!rst_n)
      bus_write_enable |-> bus_byte_enable == exp_be[store_idx])
    else report_mismatch("store_byte_enable", {28'b0, exp_be[$sampled(store_idx)]},
                         {28'b0, $sampled(bus_byte_enable)});

  assert property (@(posedge clock) disable iff (!rst_n)
      bus_write_enable |-> (bus_write_data & lane_mask(bus_byte_enable)) ==
                           (exp_data[store_idx] & lane_mask(exp_be[store_idx])))
    else report_mismatch("store_data", exp_data[$sampled(store_idx)],
                         $sampled(bus_write_data) & lane_mask($sampled(bus_byte_enable)));

  // Only loads read the data bus
  assert property (@(posedge clock) disable iff (!rst_n)
      bus_read_enable == (inst[6:0] == OPC_LOAD))
    else report_mismatch("read_enable", {31'b0, $sampled(inst[6:0]) == OPC_LOAD},
                         {31'b0, $sampled(bus_read_enable)});

  initial begin
    int i;
    rst_n    = 1'b0;
    inst     = 32'h0000_0013;  // NOP until the first fetch
    failures = 0;
    seed     = 32'h6142_3341;
    for (i = 0; i < 256; i++) begin
      dmem[i]    = lcg_next() ^ (32'(i) << 2);
      ref_mem[i] = dmem[i];
    end
    build_program();
    cycle_limit = 2 * prog_len + 16;  // Straight-line program, one cycle per instruction

    repeat (4) @(posedge clock);
    #1 rst_n = 1'b1;
    last_pc = RESET_PC;
    cycles  = 0;
    done    = 1'b0;
    while (!done) begin
      @(posedge clock);
      #2;
      cycles++;
      if (pc == last_pc) begin
        done = 1'b1;  // Final self-jump reached
      end else if (cycles >= cycle_limit) begin
        failures++;
        $display("Timeout: program did not reach its final self-jump in %0d cycles", cycles);
        done = 1'b1;
      end
      last_pc = pc;
    end

    if (store_idx != n_exp) begin
      failures++;
      $display("Wrong number of stores: expected %0d, saw %0d", n_exp, store_idx);
    end
    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches + failures == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* core/riscv_core.sv */
// Top level of the single-cycle RV32I core.
// Instruction fetch and data bus are combinational; the clock edge commits state.

`timescale 1ns/1ps

module riscv_core
  import riscv_pkg::*;
(
  input  logic            clock,
  input  logic            rst_n,
  input  logic [XLEN-1:0] inst,
  output logic [XLEN-1:0] pc,
  output logic [XLEN-1:0] bus_address,
  input  logic [XLEN-1:0] bus_read_data,
  output logic [XLEN-1:0] bus_write_data,
  output logic [3:0]      bus_byte_enable,
  output logic            bus_read_enable,
  output logic            bus_write_enable
);

  logic [6:0]      inst_opcode;
  logic [2:0]      inst_funct3;
  logic [6:0]      inst_funct7;
  logic            alu_result_equal_zero;
  logic [4:0]      alu_function;
  logic            alu_operand_a_select;
  logic            alu_operand_b_select;
  logic [2:0]      reg_writeback_select;
  logic [1:0]      next_pc_select;
  logic            pc_write_enable;
  logic            regfile_write_enable;
  logic            data_mem_read_enable;
  logic            data_mem_write_enable;
  logic [XLEN-1:0] data_mem_address;
  logic [XLEN-1:0] data_mem_write_data;
  logic [XLEN-1:0] data_mem_read_data;

  singlecycle_datapath datapath (
    .clock                 (clock),
    .rst_n                 (rst_n),
    .inst                  (inst),
    .pc                    (pc),
    .inst_opcode           (inst_opcode),
    .inst_funct3           (inst_funct3),
    .inst_funct7           (inst_funct7),
    .alu_result_equal_zero (alu_result_equal_zero),
    .data_mem_address      (data_mem_address),
    .data_mem_write_data   (data_mem_write_data),
    .data_mem_read_data    (data_mem_read_data),
    .alu_function          (alu_function),
    .alu_operand_a_select  (alu_operand_a_select),
    .alu_operand_b_select  (alu_operand_b_select),
    .reg_writeback_select  (reg_writeback_select),
    .next_pc_select        (next_pc_select),
    .pc_write_enable       (pc_write_enable),
    .regfile_write_enable  (regfile_write_enable)
  );

  singlecycle_ctlpath ctlpath (
    .inst_opcode           (inst_opcode),
    .inst_funct3           (inst_funct3),
    .inst_funct7           (inst_funct7),
    .alu_result_equal_zero (alu_result_equal_zero),
    .alu_function          (alu_function),
    .alu_operand_a_select  (alu_operand_a_select),
    .alu_operand_b_select  (alu_operand_b_select),
    .reg_writeback_select  (reg_writeback_select),
    .next_pc_select        (next_pc_select),
    .pc_write_enable       (pc_write_enable),
    .regfile_write_enable  (regfile_write_enable),
    .data_mem_read_enable  (data_mem_read_enable),
    .data_mem_write_enable (data_mem_write_enable)
  );

  data_memory_interface dmem (
    .read_enable      (data_mem_read_enable),
    .write_enable     (data_mem_write_enable),
    .data_format      (inst_funct3),  // Load/store funct3 is the format code
    .address          (data_mem_address),
    .write_data       (data_mem_write_data),
    .read_data        (data_mem_read_data),
    .bus_address      (bus_address),
    .bus_read_data    (bus_read_data),
    .bus_write_data   (bus_write_data),
    .bus_byte_enable  (bus_byte_enable),
    .bus_read_enable  (bus_read_enable),
    .bus_write_enable (bus_write_enable)
  );

endmodule

/* core/data_memory_interface.sv */
// Byte-lane steering between the core and a 32-bit data bus.
// Stores replicate data across lanes; loads align and extend the addressed lane.

`timescale 1ns/1ps

module data_memory_interface
  import riscv_pkg::*;
(
  input  logic            read_enable,
  input  logic            write_enable,
  input  logic [2:0]      data_format,
  input  logic [XLEN-1:0] address,
  input  logic [XLEN-1:0] write_data,
  output logic [XLEN-1:0] read_data,
  output logic [XLEN-1:0] bus_address,
  input  logic [XLEN-1:0] bus_read_data,
  output logic [XLEN-1:0] bus_write_data,
  output logic [3:0]      bus_byte_enable,
  output logic            bus_read_enable,
  output logic            bus_write_enable
);

  logic [XLEN-1:0] byte_shifted;
  logic [XLEN-1:0] half_shifted;

  assign bus_address      = {address[XLEN-1:2], 2'b00};  // Word aligned
  assign bus_read_enable  = read_enable;
  assign bus_write_enable = write_enable;

  always_comb begin
    case (data_format)
      FMT_B: begin
        bus_write_data  = {4{write_data[7:0]}};
        bus_byte_enable = 4'b0001 << address[1:0];
      end
      FMT_H: begin
        bus_write_data  = {2{write_data[15:0]}};
        bus_byte_enable = address[1] ? 4'b1100 : 4'b0011;  // Bit 0 is ignored
      end
      default: begin
        bus_write_data  = write_data;
        bus_byte_enable = 4'b1111;
      end
    endcase
  end

  assign byte_shifted = bus_read_data >> {address[1:0], 3'b000};
  assign half_shifted = bus_read_data >> {address[1], 4'b0000};

  always_comb begin
    case (data_format)
      FMT_B:   read_data = {{24{byte_shifted[7]}}, byte_shifted[7:0]};
      FMT_BU:  read_data = {24'b0, byte_shifted[7:0]};
      FMT_H:   read_data = {{16{half_shifted[15]}}, half_shifted[15:0]};
      FMT_HU:  read_data = {16'b0, half_shifted[15:0]};
      FMT_W:   read_data = bus_read_data;
      default: read_data = bus_read_data;
    endcase
  end

endmodule

/* core/singlecycle_ctlpath.sv */
// Combinational control path of the single-cycle core.
// Decodes opcode, funct3 and funct7 into datapath selects, enables and branch outcome.

`timescale 1ns/1ps

module singlecycle_ctlpath
  import riscv_pkg::*;
(
  input  logic [6:0] inst_opcode,
  input  logic [2:0] inst_funct3,
  input  logic [6:0] inst_funct7,
  input  logic       alu_result_equal_zero,
  output logic [4:0] alu_function,
  output logic       alu_operand_a_select,
  output logic       alu_operand_b_select,
  output logic [2:0] reg_writeback_select,
  output logic [1:0] next_pc_select,
  output logic       pc_write_enable,
  output logic       regfile_write_enable,
  output logic       data_mem_read_enable,
  output logic       data_mem_write_enable
);

  logic branch_taken;

  // Maps funct3 of OP and OP-IMM to an ALU function
  function automatic logic [4:0] arith_function(input logic [2:0] funct3, input logic alt);
    case (funct3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // Bit 0 inverts the sense and bit 2 marks the SLT/SLTU group, whose
  // result is nonzero when the comparison holds
  assign branch_taken = alu_result_equal_zero ^ inst_funct3[0] ^ inst_funct3[2];

  always_comb begin
    alu_function          = ALU_ADD;
    alu_operand_a_select  = 1'b0;
    alu_operand_b_select  = 1'b0;
    reg_writeback_select  = WB_ALU;
    next_pc_select        = NPC_PLUS_4;
    pc_write_enable       = 1'b1;  // Every instruction retires in one cycle
    regfile_write_enable  = 1'b0;
    data_mem_read_enable  = 1'b0;
    data_mem_write_enable = 1'b0;

    case (inst_opcode)
      OPC_LUI: begin
        alu_function         = ALU_PASS_B;
        alu_operand_b_select = 1'b1;
        regfile_write_enable = 1'b1;
      end
      OPC_AUIPC: begin
        alu_operand_a_select = 1'b1;
        alu_operand_b_select = 1'b1;
        regfile_write_enable = 1'b1;
      end
      OPC_JAL: begin
        reg_writeback_select = WB_PC_PLUS_4;
        next_pc_select       = NPC_BRANCH;  // pc plus J immediate
        regfile_write_enable = 1'b1;
      end
      OPC_JALR: begin
        alu_operand_b_select = 1'b1;
        reg_writeback_select = WB_PC_PLUS_4;
        next_pc_select       = NPC_JALR;
        regfile_write_enable = 1'b1;
      end
      OPC_BRANCH: begin
        case (inst_funct3[2:1])
          2'b10:   alu_function = ALU_SLT;
          2'b11:   alu_function = ALU_SLTU;
          default: alu_function = ALU_SUB;
        endcase
        next_pc_select = branch_taken ? NPC_BRANCH : NPC_PLUS_4;
      end
      OPC_LOAD: begin
        alu_operand_b_select = 1'b1;
        reg_writeback_select = WB_MEM;
        regfile_write_enable = 1'b1;
        data_mem_read_enable = 1'b1;
      end
      OPC_STORE: begin
        alu_operand_b_select  = 1'b1;
        data_mem_write_enable = 1'b1;
      end
      OPC_OP_IMM: begin
        // Only SRAI carries funct7; in ADDI those bits are immediate
        alu_function = arith_function(inst_funct3,
                                      inst_funct7[5] && inst_funct3 == 3'b101);
        alu_operand_b_select = 1'b1;
        regfile_write_enable = 1'b1;
      end
      OPC_OP: begin
        alu_function         = arith_function(inst_funct3, inst_funct7[5]);
        regfile_write_enable = 1'b1;
      end
      default: begin
      end
    endcase
  end

endmodule

/* core/singlecycle_datapath.sv */
// Datapath of the single-cycle core: pc, immediates, ALU, muxes and register file.
// Steered entirely by the combinational control path.

`timescale 1ns/1ps

module singlecycle_datapath
  import riscv_pkg::*;
(
  input  logic            clock,
  input  logic            rst_n,
  input  inst_t           inst,
  output logic [XLEN-1:0] pc,
  output logic [6:0]      inst_opcode,
  output logic [2:0]      inst_funct3,
  output logic [6:0]      inst_funct7,
  output logic            alu_result_equal_zero,
  output logic [XLEN-1:0] data_mem_address,
  output logic [XLEN-1:0] data_mem_write_data,
  input  logic [XLEN-1:0] data_mem_read_data,
  input  logic [4:0]      alu_function,
  input  logic            alu_operand_a_select,
  input  logic            alu_operand_b_select,
  input  logic [2:0]      reg_writeback_select,
  input  logic [1:0]      next_pc_select,
  input  logic            pc_write_enable,
  input  logic            regfile_write_enable
);

  logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [XLEN-1:0] alu_imm;
  logic [XLEN-1:0] target_imm;
  logic [XLEN-1:0] rs1_data, rs2_data;
  logic [XLEN-1:0] alu_operand_a, alu_operand_b;
  logic [XLEN-1:0] alu_result;
  logic [XLEN-1:0] writeback_data;
  logic [XLEN-1:0] pc_plus_4, pc_plus_imm, next_pc;

  assign inst_opcode = inst.r_type.opcode;
  assign inst_funct3 = inst.r_type.funct3;
  assign inst_funct7 = inst.r_type.funct7;

  // ======================================================================
  // Immediate generation
  // ======================================================================
  assign imm_i = {{20{inst.i_type.imm_11_0[11]}}, inst.i_type.imm_11_0};
  assign imm_s = {{20{inst.s_type.imm_11_5[6]}}, inst.s_type.imm_11_5, inst.s_type.imm_4_0};
  assign imm_b = {{19{inst.b_type.imm_12}}, inst.b_type.imm_12, inst.b_type.imm_11,
                  inst.b_type.imm_10_5, inst.b_type.imm_4_1, 1'b0};
  assign imm_u = {inst.u_type.imm_31_12, 12'b0};
  assign imm_j = {{11{inst.j_type.imm_20}}, inst.j_type.imm_20, inst.j_type.imm_19_12,
                  inst.j_type.imm_11, inst.j_type.imm_10_1, 1'b0};

  always_comb begin
    case (inst_opcode)
      OPC_LUI, OPC_AUIPC: alu_imm = imm_u;
      OPC_STORE:          alu_imm = imm_s;
      default:            alu_imm = imm_i;  // OP-IMM, loads, JALR
    endcase
  end

  assign target_imm = (inst_opcode == OPC_JAL) ? imm_j : imm_b;

  register_file regfile (
    .clock        (clock),
    .rst_n        (rst_n),
    .rs1_index    (inst.r_type.rs1),
    .rs2_index    (inst.r_type.rs2),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .rd_index     (inst.r_type.rd),
    .rd_data      (writeback_data),
    .write_enable (regfile_write_enable)
  );

  // ======================================================================
  // ALU
  // ======================================================================
  assign alu_operand_a = alu_operand_a_select ? pc : rs1_data;
  assign alu_operand_b = alu_operand_b_select ? alu_imm : rs2_data;

  always_comb begin
    case (alu_function)
      ALU_ADD:    alu_result = alu_operand_a + alu_operand_b;
      ALU_SUB:    alu_result = alu_operand_a - alu_operand_b;
      ALU_SLL:    alu_result = alu_operand_a << alu_operand_b[4:0];
      ALU_SLT:    alu_result = {{(XLEN-1){1'b0}},
                                $signed(alu_operand_a) < $signed(alu_operand_b)};
      ALU_SLTU:   alu_result = {{(XLEN-1){1'b0}}, alu_operand_a < alu_operand_b};
      ALU_XOR:    alu_result = alu_operand_a ^ alu_operand_b;
      ALU_SRL:    alu_result = alu_operand_a >> alu_operand_b[4:0];
      ALU_SRA:    alu_result = $signed(alu_operand_a) >>> alu_operand_b[4:0];
      ALU_OR:     alu_result = alu_operand_a | alu_operand_b;
      ALU_AND:    alu_result = alu_operand_a & alu_operand_b;
      ALU_PASS_B: alu_result = alu_operand_b;
      default:    alu_result = alu_operand_a + alu_operand_b;
    endcase
  end

  assign alu_result_equal_zero = (alu_result == '0);  // Feeds the branch decision
  assign data_mem_address      = alu_result;
  assign data_mem_write_data   = rs2_data;

  always_comb begin
    case (reg_writeback_select)
      WB_MEM:       writeback_data = data_mem_read_data;
      WB_PC_PLUS_4: writeback_data = pc_plus_4;  // Link value of JAL and JALR
      default:      writeback_data = alu_result;
    endcase
  end

  // ======================================================================
  // Next pc and the pc register
  // ======================================================================
  assign pc_plus_4   = pc + 32'd4;
  assign pc_plus_imm = pc + target_imm;

  always_comb begin
    case (next_pc_select)
      NPC_BRANCH: next_pc = pc_plus_imm;
      NPC_JALR:   next_pc = {alu_result[XLEN-1:1], 1'b0};
      default:    next_pc = pc_plus_4;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else if (pc_write_enable) begin
      pc <= next_pc;
    end
  end

endmodule

/* core/register_file.sv */
// Integer register file x1..x31 with two combinational read ports.
// x0 is not stored and always reads as zero.

`timescale 1ns/1ps

module register_file
  import riscv_pkg::*;
(
  input  logic            clock,
  input  logic            rst_n,
  input  logic [4:0]      rs1_index,
  input  logic [4:0]      rs2_index,
  output logic [XLEN-1:0] rs1_data,
  output logic [XLEN-1:0] rs2_data,
  input  logic [4:0]      rd_index,
  input  logic [XLEN-1:0] rd_data,
  input  logic            write_enable
);

  logic [XLEN-1:0] regs [1:31];

  assign rs1_data = (rs1_index == 5'd0) ? '0 : regs[rs1_index];
  assign rs2_data = (rs2_index == 5'd0) ? '0 : regs[rs2_index];

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write_enable && rd_index != 5'd0) begin
      regs[rd_index] <= rd_data;  // Writes to x0 are dropped
    end
  end

endmodule

/* common/riscv_pkg.sv */
// Shared constants and types for the single-cycle RV32I core.
// Every RTL module pulls what it needs from here with a wildcard import.

package riscv_pkg;

  localparam int XLEN = 32;
  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

  // ======================================================================
  // Major opcodes
  // ======================================================================
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  // ALU functions
  localparam logic [4:0] ALU_ADD    = 5'd0;
  localparam logic [4:0] ALU_SUB    = 5'd1;
  localparam logic [4:0] ALU_SLL    = 5'd2;
  localparam logic [4:0] ALU_SLT    = 5'd3;
  localparam logic [4:0] ALU_SLTU   = 5'd4;
  localparam logic [4:0] ALU_XOR    = 5'd5;
  localparam logic [4:0] ALU_SRL    = 5'd6;
  localparam logic [4:0] ALU_SRA    = 5'd7;
  localparam logic [4:0] ALU_OR     = 5'd8;
  localparam logic [4:0] ALU_AND    = 5'd9;
  localparam logic [4:0] ALU_PASS_B = 5'd10;  // LUI forwards the U immediate

  // Writeback and next-pc mux selects
  localparam logic [2:0] WB_ALU       = 3'd0;
  localparam logic [2:0] WB_MEM       = 3'd1;
  localparam logic [2:0] WB_PC_PLUS_4 = 3'd2;

  localparam logic [1:0] NPC_PLUS_4 = 2'd0;
  localparam logic [1:0] NPC_BRANCH = 2'd1;  // Also used by JAL
  localparam logic [1:0] NPC_JALR   = 2'd2;

  // Data formats match funct3 of loads and stores
  localparam logic [2:0] FMT_B  = 3'b000;
  localparam logic [2:0] FMT_H  = 3'b001;
  localparam logic [2:0] FMT_W  = 3'b010;
  localparam logic [2:0] FMT_BU = 3'b100;
  localparam logic [2:0] FMT_HU = 3'b101;

  // ======================================================================
  // Instruction word with one view per encoding format
  // ======================================================================
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_type;
    struct packed {
      logic [11:0] imm_11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_type;
    struct packed {
      logic [6:0] imm_11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_4_0;
      logic [6:0] opcode;
    } s_type;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b_type;
    struct packed {
      logic [19:0] imm_31_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u_type;
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j_type;
  } inst_t;

endpackage
